// ==== axi_demux.f ====
hw/axi_demux_pkg.sv
hw/axi_demux_id_counters.sv
hw/axi_demux_aw_ctrl.sv
hw/axi_demux_w_route.sv
hw/axi_demux_ar_ctrl.sv
hw/axi_demux_resp_arb.sv
hw/axi_demux.sv
test/tb_clock_gen.sv
test/axi_demux_props.sv
test/axi_demux_tb.sv

// ==== hw/axi_demux.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_demux
  import axi_demux_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        reset_i,
  // Slave side
  input  mst_req_t                    slv_req_i,
  input  sel_t                        slv_aw_select_i,
  input  sel_t                        slv_ar_select_i,
  output mst_resp_t                   slv_resp_o,
  // Master ports
  output mst_req_t  [NUM_MST_PORTS-1:0] mst_reqs_o,
  input  mst_resp_t [NUM_MST_PORTS-1:0] mst_resps_i
);

  sel_t aw_lookup_sel;
  sel_t ar_lookup_sel;
  logic aw_occupied;
  logic ar_occupied;
  logic aw_cnt_full;
  logic ar_cnt_full;
  logic aw_push;
  logic ar_push;
  logic w_fifo_full;
  logic b_pop;
  logic r_pop;

  logic slv_aw_ready;
  logic slv_w_ready;
  logic slv_ar_ready;
  logic slv_b_valid;
  logic slv_r_valid;
  b_chan_t slv_b;
  r_chan_t slv_r;

  logic    [NUM_MST_PORTS-1:0] mst_aw_ready;
  logic    [NUM_MST_PORTS-1:0] mst_aw_valid;
  logic    [NUM_MST_PORTS-1:0] mst_w_ready;
  logic    [NUM_MST_PORTS-1:0] mst_w_valid;
  logic    [NUM_MST_PORTS-1:0] mst_ar_ready;
  logic    [NUM_MST_PORTS-1:0] mst_ar_valid;
  logic    [NUM_MST_PORTS-1:0] mst_b_valid;
  logic    [NUM_MST_PORTS-1:0] mst_b_ready;
  logic    [NUM_MST_PORTS-1:0] mst_r_valid;
  logic    [NUM_MST_PORTS-1:0] mst_r_ready;
  b_chan_t [NUM_MST_PORTS-1:0] mst_b;
  r_chan_t [NUM_MST_PORTS-1:0] mst_r;

  // ------------------------------------------------------------
  // Write path
  // ------------------------------------------------------------
  axi_demux_id_counters u_aw_ids (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .lookup_id_i       (slv_req_i.aw.id[LOOK_BITS-1:0]),
    .lookup_sel_o      (aw_lookup_sel),
    .lookup_occupied_o (aw_occupied),
    .full_o            (aw_cnt_full),
    .push_i            (aw_push),
    .push_id_i         (slv_req_i.aw.id[LOOK_BITS-1:0]),
    .push_sel_i        (slv_aw_select_i),
    .pop_i             (b_pop),
    .pop_id_i          (slv_b.id[LOOK_BITS-1:0])
  );

  axi_demux_aw_ctrl u_aw_ctrl (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .slv_aw_valid_i    (slv_req_i.aw_valid),
    .slv_aw_sel_i      (slv_aw_select_i),
    .lookup_sel_i      (aw_lookup_sel),
    .lookup_occupied_i (aw_occupied),
    .cnt_full_i        (aw_cnt_full),
    .fifo_full_i       (w_fifo_full),
    .mst_aw_ready_i    (mst_aw_ready),
    .slv_aw_ready_o    (slv_aw_ready),
    .aw_push_o         (aw_push),
    .mst_aw_valid_o    (mst_aw_valid)
  );

  axi_demux_w_route u_w_route (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .push_i        (aw_push),
    .push_sel_i    (slv_aw_select_i),
    .slv_w_valid_i (slv_req_i.w_valid),
    .slv_w_last_i  (slv_req_i.w.last),
    .mst_w_ready_i (mst_w_ready),
    .fifo_full_o   (w_fifo_full),
    .slv_w_ready_o (slv_w_ready),
    .mst_w_valid_o (mst_w_valid)
  );

  axi_demux_resp_arb #(
    .payload_t (b_chan_t)
  ) u_b_arb (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mst_valid_i   (mst_b_valid),
    .mst_payload_i (mst_b),
    .mst_ready_o   (mst_b_ready),
    .slv_valid_o   (slv_b_valid),
    .slv_payload_o (slv_b),
    .slv_ready_i   (slv_req_i.b_ready)
  );

  assign b_pop = slv_b_valid && slv_req_i.b_ready;

  // ------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------
  axi_demux_id_counters u_ar_ids (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .lookup_id_i       (slv_req_i.ar.id[LOOK_BITS-1:0]),
    .lookup_sel_o      (ar_lookup_sel),
    .lookup_occupied_o (ar_occupied),
    .full_o            (ar_cnt_full),
    .push_i            (ar_push),
    .push_id_i         (slv_req_i.ar.id[LOOK_BITS-1:0]),
    .push_sel_i        (slv_ar_select_i),
    .pop_i             (r_pop),
    .pop_id_i          (slv_r.id[LOOK_BITS-1:0])
  );

  axi_demux_ar_ctrl u_ar_ctrl (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .slv_ar_valid_i    (slv_req_i.ar_valid),
    .slv_ar_sel_i      (slv_ar_select_i),
    .lookup_sel_i      (ar_lookup_sel),
    .lookup_occupied_i (ar_occupied),
    .cnt_full_i        (ar_cnt_full),
    .mst_ar_ready_i    (mst_ar_ready),
    .slv_ar_ready_o    (slv_ar_ready),
    .ar_push_o         (ar_push),
    .mst_ar_valid_o    (mst_ar_valid)
  );

  axi_demux_resp_arb #(
    .payload_t (r_chan_t)
  ) u_r_arb (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mst_valid_i   (mst_r_valid),
    .mst_payload_i (mst_r),
    .mst_ready_o   (mst_r_ready),
    .slv_valid_o   (slv_r_valid),
    .slv_payload_o (slv_r),
    .slv_ready_i   (slv_req_i.r_ready)
  );

  // Read counter drops only at the end of a burst
  assign r_pop = slv_r_valid && slv_req_i.r_ready && slv_r.last;

  // ------------------------------------------------------------
  // Bundle packing
  // ------------------------------------------------------------
  for (genvar i = 0; i < NUM_MST_PORTS; i++) begin : gen_unpack
    assign mst_aw_ready[i] = mst_resps_i[i].aw_ready;
    assign mst_w_ready[i]  = mst_resps_i[i].w_ready;
    assign mst_ar_ready[i] = mst_resps_i[i].ar_ready;
    assign mst_b_valid[i]  = mst_resps_i[i].b_valid;
    assign mst_b[i]        = mst_resps_i[i].b;
    assign mst_r_valid[i]  = mst_resps_i[i].r_valid;
    assign mst_r[i]        = mst_resps_i[i].r;
  end

  // Payloads go to every port, only the valids are steered
  always_comb begin
    for (int i = 0; i < NUM_MST_PORTS; i++) begin
      mst_reqs_o[i].aw       = slv_req_i.aw;
      mst_reqs_o[i].aw_valid = mst_aw_valid[i];
      mst_reqs_o[i].w        = slv_req_i.w;
      mst_reqs_o[i].w_valid  = mst_w_valid[i];
      mst_reqs_o[i].b_ready  = mst_b_ready[i];
      mst_reqs_o[i].ar       = slv_req_i.ar;
      mst_reqs_o[i].ar_valid = mst_ar_valid[i];
      mst_reqs_o[i].r_ready  = mst_r_ready[i];
    end
  end

  always_comb begin
    slv_resp_o.aw_ready = slv_aw_ready;
    slv_resp_o.w_ready  = slv_w_ready;
    slv_resp_o.b        = slv_b;
    slv_resp_o.b_valid  = slv_b_valid;
    slv_resp_o.ar_ready = slv_ar_ready;
    slv_resp_o.r        = slv_r;
    slv_resp_o.r_valid  = slv_r_valid;
  end

endmodule

`default_nettype wire

// ==== hw/axi_demux_ar_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_demux_ar_ctrl
  import axi_demux_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     slv_ar_valid_i,
  input  sel_t                     slv_ar_sel_i,
  input  sel_t                     lookup_sel_i,
  input  logic                     lookup_occupied_i,
  input  logic                     cnt_full_i,
  input  logic [NUM_MST_PORTS-1:0] mst_ar_ready_i,
  output logic                     slv_ar_ready_o,
  output logic                     ar_push_o,
  output logic [NUM_MST_PORTS-1:0] mst_ar_valid_o
);

  logic lock_q;
  logic allow;
  logic ar_valid;
  logic sel_ready;

  assign allow = slv_ar_valid_i && !cnt_full_i &&
                 (!lookup_occupied_i || (lookup_sel_i == slv_ar_sel_i));

  assign ar_valid  = lock_q || allow;
  assign sel_ready = mst_ar_ready_i[slv_ar_sel_i];

  assign slv_ar_ready_o = ar_valid && sel_ready;
  // Read counters count from the transfer on
  assign ar_push_o      = ar_valid && sel_ready;

  always_comb begin
    mst_ar_valid_o = '0;
    if (ar_valid) begin
      mst_ar_valid_o[slv_ar_sel_i] = 1'b1;
    end
  end

  // Hold the offered AR until it is taken
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q <= 1'b0;
    end else if (lock_q) begin
      if (sel_ready) begin
        lock_q <= 1'b0;
      end
    end else if (allow && !sel_ready) begin
      lock_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/axi_demux_aw_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_demux_aw_ctrl
  import axi_demux_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     slv_aw_valid_i,
  input  sel_t                     slv_aw_sel_i,
  input  sel_t                     lookup_sel_i,
  input  logic                     lookup_occupied_i,
  input  logic                     cnt_full_i,
  input  logic                     fifo_full_i,
  input  logic [NUM_MST_PORTS-1:0] mst_aw_ready_i,
  output logic                     slv_aw_ready_o,
  output logic                     aw_push_o,
  output logic [NUM_MST_PORTS-1:0] mst_aw_valid_o
);

  logic lock_q;
  logic allow;
  logic aw_valid;
  logic sel_ready;

  // ------------------------------------------------------------
  // Acceptance
  // ------------------------------------------------------------
  // Same ID may only go to the port it is already outstanding at
  assign allow = slv_aw_valid_i && !cnt_full_i && !fifo_full_i &&
                 (!lookup_occupied_i || (lookup_sel_i == slv_aw_sel_i));

  assign aw_valid  = lock_q || allow;
  assign sel_ready = mst_aw_ready_i[slv_aw_sel_i];

  assign slv_aw_ready_o = aw_valid && sel_ready;

  // Counters and W FIFO see the AW on its first offer only
  assign aw_push_o = allow && !lock_q;

  always_comb begin
    mst_aw_valid_o = '0;
    if (aw_valid) begin
      mst_aw_valid_o[slv_aw_sel_i] = 1'b1;
    end
  end

  // Decision stays offered until the selected port takes it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q <= 1'b0;
    end else if (lock_q) begin
      if (sel_ready) begin
        lock_q <= 1'b0;
      end
    end else if (allow && !sel_ready) begin
      lock_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/axi_demux_id_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_demux_id_counters
  import axi_demux_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  // Lookup
  input  look_id_t lookup_id_i,
  output sel_t     lookup_sel_o,
  output logic     lookup_occupied_o,
  output logic     full_o,
  // Push on an accepted address
  input  logic     push_i,
  input  look_id_t push_id_i,
  input  sel_t     push_sel_i,
  // Pop on the final response
  input  logic     pop_i,
  input  look_id_t pop_id_i
);

  logic [CNT_WIDTH-1:0] cnt_vec [2**LOOK_BITS];
  sel_t                 sel_vec [2**LOOK_BITS];
  logic [2**LOOK_BITS-1:0] cnt_full;

  assign lookup_sel_o      = sel_vec[lookup_id_i];
  assign lookup_occupied_o = |cnt_vec[lookup_id_i];
  assign full_o            = |cnt_full;

  // ------------------------------------------------------------
  // One up/down counter and stored port per ID
  // ------------------------------------------------------------
  for (genvar i = 0; i < 2**LOOK_BITS; i++) begin : gen_cnt
    logic                 inc;
    logic                 dec;
    logic [CNT_WIDTH-1:0] cnt_q;
    sel_t                 sel_q;

    assign inc = push_i && (push_id_i == look_id_t'(i));
    assign dec = pop_i && (pop_id_i == look_id_t'(i));

    // Push and pop on the same ID leave the count alone
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        cnt_q <= '0;
      end else if (inc && !dec) begin
        cnt_q <= cnt_q + CNT_WIDTH'(1);
      end else if (dec && !inc) begin
        cnt_q <= cnt_q - CNT_WIDTH'(1);
      end
    end

    // Port is only looked at while the count is nonzero
    always_ff @(posedge clk_i) begin
      if (inc) begin
        sel_q <= push_sel_i;
      end
    end

    assign cnt_vec[i]  = cnt_q;
    assign sel_vec[i]  = sel_q;
    assign cnt_full[i] = &cnt_q;
  end

endmodule

`default_nettype wire

// ==== hw/axi_demux_pkg.sv ====
`default_nettype none

package axi_demux_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------
  localparam int unsigned NUM_MST_PORTS = 4;
  localparam int unsigned SEL_WIDTH     = 2;
  localparam int unsigned ID_WIDTH      = 4;
  // Lower ID bits that get their own in-flight counter
  localparam int unsigned LOOK_BITS     = 2;
  localparam int unsigned ADDR_WIDTH    = 32;
  localparam int unsigned DATA_WIDTH    = 32;
  localparam int unsigned LEN_WIDTH     = 8;
  // Depth of the W select FIFO
  localparam int unsigned MAX_TRANS     = 4;
  localparam int unsigned CNT_WIDTH     = 2;

  typedef logic [SEL_WIDTH-1:0] sel_t;
  typedef logic [LOOK_BITS-1:0] look_id_t;

  // ------------------------------------------------------------
  // Channel payloads
  // ------------------------------------------------------------
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } aw_chan_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } ar_chan_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } w_chan_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0] id;
    logic [1:0]          resp;
  } b_chan_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [DATA_WIDTH-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } r_chan_t;

  // Request and response bundles, same shape on both sides
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } mst_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } mst_resp_t;

endpackage

`default_nettype wire

// ==== hw/axi_demux_resp_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_demux_resp_arb
  import axi_demux_pkg::*;
#(
  parameter type payload_t = b_chan_t
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic     [NUM_MST_PORTS-1:0]       mst_valid_i,
  input  payload_t [NUM_MST_PORTS-1:0]       mst_payload_i,
  output logic     [NUM_MST_PORTS-1:0]       mst_ready_o,
  output logic                               slv_valid_o,
  output payload_t                           slv_payload_o,
  input  logic                               slv_ready_i
);

  sel_t prio_q;
  logic lock_q;
  sel_t lock_idx_q;
  sel_t gnt_idx;
  sel_t cand;
  logic found;

  // ------------------------------------------------------------
  // Round-robin pick, starting at the priority pointer
  // ------------------------------------------------------------
  always_comb begin
    gnt_idx = prio_q;
    found   = 1'b0;
    cand    = prio_q;
    for (int i = 0; i < NUM_MST_PORTS; i++) begin
      cand = prio_q + sel_t'(i);
      if (!found && mst_valid_i[cand]) begin
        gnt_idx = cand;
        found   = 1'b1;
      end
    end
    // A held grant wins over the search
    if (lock_q) begin
      gnt_idx = lock_idx_q;
    end
  end

  assign slv_valid_o   = mst_valid_i[gnt_idx];
  assign slv_payload_o = mst_payload_i[gnt_idx];

  always_comb begin
    mst_ready_o = '0;
    mst_ready_o[gnt_idx] = slv_ready_i;
  end

  // ------------------------------------------------------------
  // Lock-in and pointer update
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (slv_valid_o) begin
      if (slv_ready_i) begin
        lock_q <= 1'b0;
        prio_q <= gnt_idx + sel_t'(1);
      end else begin
        lock_q     <= 1'b1;
        lock_idx_q <= gnt_idx;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/axi_demux_w_route.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_demux_w_route
  import axi_demux_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     push_i,
  input  sel_t                     push_sel_i,
  input  logic                     slv_w_valid_i,
  input  logic                     slv_w_last_i,
  input  logic [NUM_MST_PORTS-1:0] mst_w_ready_i,
  output logic                     fifo_full_o,
  output logic                     slv_w_ready_o,
  output logic [NUM_MST_PORTS-1:0] mst_w_valid_o
);

  typedef logic [$clog2(MAX_TRANS)-1:0] ptr_t;
  typedef logic [$clog2(MAX_TRANS):0]   cnt_t;

  sel_t mem [MAX_TRANS];
  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t count_q;
  logic empty;
  logic pop;
  sel_t head_sel;

  assign empty       = (count_q == '0);
  assign fifo_full_o = (count_q == cnt_t'(MAX_TRANS));
  assign head_sel    = mem[rd_ptr_q];

  // ------------------------------------------------------------
  // Beat steering to the port at the FIFO head
  // ------------------------------------------------------------
  always_comb begin
    mst_w_valid_o = '0;
    slv_w_ready_o = 1'b0;
    if (!empty) begin
      mst_w_valid_o[head_sel] = slv_w_valid_i;
      slv_w_ready_o           = mst_w_ready_i[head_sel];
    end
  end

  // Head is done once the last beat has gone
  assign pop = slv_w_valid_i && slv_w_ready_o && slv_w_last_i;

  // ------------------------------------------------------------
  // Select FIFO
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + ptr_t'(1);
      end
      if (push_i && !pop) begin
        count_q <= count_q + cnt_t'(1);
      end else if (pop && !push_i) begin
        count_q <= count_q - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_sel_i;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 \
    --top-module axi_demux_tb -f axi_demux.f -o axi_demux_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/axi_demux_sim +verilator+error+limit+100 > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error status"
  exit 1
fi

cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== test/axi_demux_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_demux_props
  import axi_demux_pkg::*;
(
  input logic                           clk_i,
  input logic                           reset_i,
  input mst_req_t                       slv_req_i,
  input mst_resp_t                      slv_resp_i,
  input mst_req_t  [NUM_MST_PORTS-1:0]  mst_reqs_i
);

  int unsigned fail_count = 0;

  logic [NUM_MST_PORTS-1:0] aw_valid;
  logic [NUM_MST_PORTS-1:0] w_valid;
  logic [NUM_MST_PORTS-1:0] ar_valid;
  logic                     any_valid;

  for (genvar i = 0; i < NUM_MST_PORTS; i++) begin : gen_vld
    assign aw_valid[i] = mst_reqs_i[i].aw_valid;
    assign w_valid[i]  = mst_reqs_i[i].w_valid;
    assign ar_valid[i] = mst_reqs_i[i].ar_valid;
  end

  assign any_valid = (|aw_valid) || (|w_valid) || (|ar_valid) ||
                     slv_resp_i.b_valid || slv_resp_i.r_valid;

  // ------------------------------------------------------------
  // Response channels under back-pressure
  // ------------------------------------------------------------
  b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_resp_i.b_valid && !slv_req_i.b_ready |=>
      slv_resp_i.b_valid && $stable(slv_resp_i.b))
    else begin
      fail_count++;
      $error("slave B dropped or changed while stalled");
    end

  r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_resp_i.r_valid && !slv_req_i.r_ready |=>
      slv_resp_i.r_valid && $stable(slv_resp_i.r))
    else begin
      fail_count++;
      $error("slave R dropped or changed while stalled");
    end

  // At most one master port sees an AW
  aw_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(aw_valid))
    else begin
      fail_count++;
      $error("more than one master port has aw_valid");
    end

  reset_quiet: assert property (@(posedge clk_i) reset_i |=> !any_valid)
    else begin
      fail_count++;
      $error("valid raised in the cycle after reset");
    end

endmodule

bind axi_demux axi_demux_props u_props (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .slv_req_i  (slv_req_i),
  .slv_resp_i (slv_resp_o),
  .mst_reqs_i (mst_reqs_o)
);

`default_nettype wire

// ==== test/axi_demux_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_demux_tb
  import axi_demux_pkg::*;
();

  localparam int TIMEOUT = 50;

  logic      clk;
  logic      reset;
  mst_req_t  slv_req;
  sel_t      slv_aw_sel;
  sel_t      slv_ar_sel;
  mst_resp_t slv_resp;
  mst_req_t  [NUM_MST_PORTS-1:0] mst_reqs;
  mst_resp_t [NUM_MST_PORTS-1:0] mst_resps;

  int     errors;
  int     timeouts;
  integer seed;
  logic [ID_WIDTH-1:0] b_got [$];

  logic [NUM_MST_PORTS-1:0] aw_vld;
  logic [NUM_MST_PORTS-1:0] w_vld;
  logic [NUM_MST_PORTS-1:0] ar_vld;

  tb_clock_gen u_clk (
    .clk_o (clk)
  );

  axi_demux u_dut (
    .clk_i           (clk),
    .reset_i         (reset),
    .slv_req_i       (slv_req),
    .slv_aw_select_i (slv_aw_sel),
    .slv_ar_select_i (slv_ar_sel),
    .slv_resp_o      (slv_resp),
    .mst_reqs_o      (mst_reqs),
    .mst_resps_i     (mst_resps)
  );

  for (genvar i = 0; i < NUM_MST_PORTS; i++) begin : gen_vld
    assign aw_vld[i] = mst_reqs[i].aw_valid;
    assign w_vld[i]  = mst_reqs[i].w_valid;
    assign ar_vld[i] = mst_reqs[i].ar_valid;
  end

  // ------------------------------------------------------------
  // Checking helpers
  // ------------------------------------------------------------
  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("error at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout at %0t ns while waiting for %s", $time, what);
  endtask

  function automatic logic [NUM_MST_PORTS-1:0] port_mask(input sel_t sel);
    logic [NUM_MST_PORTS-1:0] m;
    m      = '0;
    m[sel] = 1'b1;
    return m;
  endfunction

  // ------------------------------------------------------------
  // Slave side master and port models
  // ------------------------------------------------------------
  task automatic offer_aw(input logic [ID_WIDTH-1:0] id, input sel_t sel);
    @(posedge clk);
    slv_req.aw.id    <= id;
    slv_req.aw.addr  <= $random(seed);
    slv_req.aw.len   <= '0;
    slv_req.aw_valid <= 1'b1;
    slv_aw_sel       <= sel;
  endtask

  task automatic wait_aw(input sel_t sel);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!slv_resp.aw_ready && cycles < TIMEOUT);
    if (!slv_resp.aw_ready) begin
      report_timeout("slave aw_ready");
    end else begin
      check_val("mst aw_valid", 64'(port_mask(sel)), 64'(aw_vld));
      check_val("mst aw.id", 64'(slv_req.aw.id), 64'(mst_reqs[sel].aw.id));
    end
    @(posedge clk);
    slv_req.aw_valid <= 1'b0;
  endtask

  task automatic send_w(input sel_t sel);
    logic [DATA_WIDTH-1:0] data;
    int cycles;
    data   = $random(seed);
    cycles = 0;
    @(posedge clk);
    slv_req.w.data  <= data;
    slv_req.w.last  <= 1'b1;
    slv_req.w_valid <= 1'b1;
    do begin
      @(negedge clk);
      cycles++;
    end while (!slv_resp.w_ready && cycles < TIMEOUT);
    if (!slv_resp.w_ready) begin
      report_timeout("slave w_ready");
    end else begin
      check_val("mst w_valid", 64'(port_mask(sel)), 64'(w_vld));
      check_val("mst w.data", 64'(data), 64'(mst_reqs[sel].w.data));
    end
    @(posedge clk);
    slv_req.w_valid <= 1'b0;
  endtask

  task automatic do_write(input logic [ID_WIDTH-1:0] id, input sel_t sel);
    offer_aw(id, sel);
    wait_aw(sel);
    send_w(sel);
  endtask

  task automatic expect_aw_blocked(input int n);
    repeat (n) begin
      @(negedge clk);
      check_val("slv aw_ready", 64'd0, 64'(slv_resp.aw_ready));
      check_val("mst aw_valid", 64'd0, 64'(aw_vld));
    end
  endtask

  // Call right after a rising edge
  task automatic raise_b(input sel_t sel, input logic [ID_WIDTH-1:0] id);
    mst_resps[sel].b.id   <= id;
    mst_resps[sel].b.resp <= 2'b00;
    mst_resps[sel].b_valid <= 1'b1;
  endtask

  // Take n B responses on the slave side, retiring each port's B on its handshake
  task automatic collect_b(input int n);
    logic [NUM_MST_PORTS-1:0] fired;
    int cycles;
    int retired;
    b_got.delete();
    cycles  = 0;
    retired = 0;
    while (b_got.size() < n && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      for (int i = 0; i < NUM_MST_PORTS; i++) begin
        fired[i] = mst_resps[i].b_valid && mst_reqs[i].b_ready;
      end
      if (slv_resp.b_valid && slv_req.b_ready) begin
        b_got.push_back(slv_resp.b.id);
      end
      retired += $countones(fired);
      @(posedge clk);
      for (int i = 0; i < NUM_MST_PORTS; i++) begin
        if (fired[i]) begin
          mst_resps[i].b_valid <= 1'b0;
        end
      end
    end
    if (b_got.size() < n) begin
      report_timeout("B responses on the slave side");
    end else begin
      check_val("port b handshakes", 64'(n), 64'(retired));
    end
  endtask

  task automatic port_b(input sel_t sel, input logic [ID_WIDTH-1:0] id);
    @(posedge clk);
    raise_b(sel, id);
    collect_b(1);
    if (b_got.size() == 1) begin
      check_val("slv b.id", 64'(id), 64'(b_got[0]));
    end
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_reset_idle();
    @(negedge clk);
    check_val("mst aw_valid", 64'd0, 64'(aw_vld));
    check_val("mst w_valid", 64'd0, 64'(w_vld));
    check_val("mst ar_valid", 64'd0, 64'(ar_vld));
    check_val("slv b_valid", 64'd0, 64'(slv_resp.b_valid));
    check_val("slv r_valid", 64'd0, 64'(slv_resp.r_valid));
  endtask

  task automatic test_write_basic();
    for (int s = 0; s < NUM_MST_PORTS; s++) begin
      do_write(ID_WIDTH'(8 + s), sel_t'(s));
      port_b(sel_t'(s), ID_WIDTH'(8 + s));
    end
  endtask

  task automatic test_read(input logic [ID_WIDTH-1:0] id, input sel_t sel, input int n);
    logic [DATA_WIDTH-1:0] data;
    int cycles;
    cycles = 0;
    @(posedge clk);
    slv_req.ar.id    <= id;
    slv_req.ar.addr  <= $random(seed);
    slv_req.ar.len   <= LEN_WIDTH'(n - 1);
    slv_req.ar_valid <= 1'b1;
    slv_ar_sel       <= sel;
    do begin
      @(negedge clk);
      cycles++;
    end while (!slv_resp.ar_ready && cycles < TIMEOUT);
    if (!slv_resp.ar_ready) begin
      report_timeout("slave ar_ready");
    end else begin
      check_val("mst ar_valid", 64'(port_mask(sel)), 64'(ar_vld));
      check_val("mst ar.len", 64'(n - 1), 64'(mst_reqs[sel].ar.len));
    end
    @(posedge clk);
    slv_req.ar_valid <= 1'b0;
    // Port answers with the burst, one beat per handshake
    for (int k = 0; k < n; k++) begin
      data = $random(seed);
      mst_resps[sel].r.id    <= id;
      mst_resps[sel].r.data  <= data;
      mst_resps[sel].r.resp  <= 2'b00;
      mst_resps[sel].r.last  <= (k == n - 1);
      mst_resps[sel].r_valid <= 1'b1;
      cycles = 0;
      do begin
        @(negedge clk);
        cycles++;
      end while (!mst_reqs[sel].r_ready && cycles < TIMEOUT);
      if (!mst_reqs[sel].r_ready) begin
        report_timeout("port r_ready");
      end else begin
        check_val("slv r_valid", 64'd1, 64'(slv_resp.r_valid));
        check_val("slv r.id", 64'(id), 64'(slv_resp.r.id));
        check_val("slv r.data", 64'(data), 64'(slv_resp.r.data));
        check_val("slv r.last", 64'(k == n - 1), 64'(slv_resp.r.last));
      end
      @(posedge clk);
    end
    mst_resps[sel].r_valid <= 1'b0;
  endtask

  task automatic test_id_order();
    do_write(4'h1, 2'd0);
    do_write(4'h1, 2'd0);
    offer_aw(4'h1, 2'd2);
    expect_aw_blocked(3);
    port_b(2'd0, 4'h1);
    // One write still open at port 0
    expect_aw_blocked(3);
    port_b(2'd0, 4'h1);
    wait_aw(2'd2);
    send_w(2'd2);
    port_b(2'd2, 4'h1);
  endtask

  task automatic test_cnt_limit();
    repeat (3) begin
      do_write(4'h2, 2'd1);
    end
    offer_aw(4'h2, 2'd1);
    expect_aw_blocked(4);
    port_b(2'd1, 4'h2);
    wait_aw(2'd1);
    send_w(2'd1);
    repeat (3) begin
      port_b(2'd1, 4'h2);
    end
  endtask

  task automatic test_b_sharing();
    int n5;
    int n7;
    n5 = 0;
    n7 = 0;
    do_write(4'h5, 2'd1);
    do_write(4'h7, 2'd3);
    @(posedge clk);
    slv_req.b_ready <= 1'b0;
    raise_b(2'd1, 4'h5);
    raise_b(2'd3, 4'h7);
    // Port 1 had the last B grant, so port 3 is first in line
    repeat (5) begin
      @(negedge clk);
      check_val("slv b_valid", 64'd1, 64'(slv_resp.b_valid));
      check_val("slv b.id", 64'h7, 64'(slv_resp.b.id));
    end
    @(posedge clk);
    slv_req.b_ready <= 1'b1;
    collect_b(2);
    foreach (b_got[i]) begin
      if (b_got[i] == 4'h5) begin
        n5++;
      end
      if (b_got[i] == 4'h7) begin
        n7++;
      end
    end
    check_val("B count for id 5", 64'd1, 64'(n5));
    check_val("B count for id 7", 64'd1, 64'(n7));
    repeat (3) begin
      @(negedge clk);
      check_val("slv b_valid", 64'd0, 64'(slv_resp.b_valid));
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    seed     = 32'hd950;
    errors   = 0;
    timeouts = 0;
    reset      <= 1'b1;
    slv_req    <= '0;
    slv_aw_sel <= '0;
    slv_ar_sel <= '0;
    slv_req.b_ready <= 1'b1;
    slv_req.r_ready <= 1'b1;
    for (int i = 0; i < NUM_MST_PORTS; i++) begin
      mst_resps[i]          <= '0;
      mst_resps[i].aw_ready <= 1'b1;
      mst_resps[i].w_ready  <= 1'b1;
      mst_resps[i].ar_ready <= 1'b1;
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    test_reset_idle();
    test_write_basic();
    test_read(4'h3, 2'd1, 4);
    test_read(4'h6, 2'd2, 1);
    test_id_order();
    test_cnt_limit();
    test_b_sharing();

    $display("checks done: %0d errors, %0d timeouts, %0d assertion failures",
             errors, timeouts, u_dut.u_props.fail_count);
    if (errors == 0 && timeouts == 0 && u_dut.u_props.fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  // 100 ns period, starts low
  initial begin
    clk_o = 1'b0;
    forever begin
      #50 clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire
